// File: source/cache_params.svh
// geometry assumes byte addresses below 256 KB; stored tags are TAG_BITS wide, address tags less
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry
// 1024 direct-mapped lines
`define BLOCKS 1024
// words per line
`define WORDS 16
// bits per word
`define SIZE 32

// address split
// word select inside a line
`define OFFSET_BITS 4
// line select
`define INDEX_BITS 10
// width of the tag store entries
`define TAG_BITS 18
// unused byte lane bits at the bottom of the address
`define BYTE_BITS 2

// backing memory
// lines held, indexed by the low line-address bits
`define MEM_LINES 4096
// cycles from read strobe to data pulse
`define MEM_LATENCY 4

`endif

// File: source/cachePkg.sv
// CPU-side view; the address tag is narrower than TAG_BITS and is zero-extended for storage
`default_nettype none
`include "cache_params.svh"

package cachePkg;

    // address tag left over after index, offset and byte lanes
    localparam int ADDR_TAG_BITS = 32 - `INDEX_BITS - `OFFSET_BITS - `BYTE_BITS;

    typedef logic [`TAG_BITS-1:0]   tag_t;
    typedef logic [`INDEX_BITS-1:0] index_t;

    // byte address, word address bits above the byte lanes
    typedef struct packed {
        logic [ADDR_TAG_BITS-1:0] tag;
        index_t                   index;
        logic [`OFFSET_BITS-1:0]  offset;
        logic [`BYTE_BITS-1:0]    byteSel;
    } cacheAddr_t;

    // one CPU access, rNw high for a read
    typedef struct packed {
        logic       rNw;
        cacheAddr_t addr;
        logic [31:0] dataIn;
    } cacheReq_t;

    // result of the tag lookup stage
    typedef struct packed {
        cacheReq_t req;
        logic      hit;
        logic      victimDirty;
        tag_t      victimTag;
    } lookupRes_t;

    // tag as kept in the tag store
    function automatic tag_t addrTag(input cacheAddr_t a);
        return tag_t'(a.tag);
    endfunction

endpackage

`default_nettype wire

// File: source/memPkg.sv
// memory-side view; line addresses cover MEM_LINES lines only, higher bits are dropped
`default_nettype none
`include "cache_params.svh"

package memPkg;

    // bits needed to pick a backing-memory line
    localparam int MEM_ADDR_BITS = $clog2(`MEM_LINES);

    typedef logic [MEM_ADDR_BITS-1:0] memAddr_t;

    // whole cache line, word 0 in the low bits
    typedef logic [`WORDS-1:0][`SIZE-1:0] line_t;

    // one transfer to the backing memory
    // write high stores line, low starts a read
    typedef struct packed {
        logic     write;
        memAddr_t lineAddr;
        line_t    line;
    } memReq_t;

endpackage

`default_nettype wire

// File: source/stageReg.sv
// flush beats hold; the payload is not reset, only its valid flag
`default_nettype none

module stageReg
    import cachePkg::*;
#(
    parameter type payload_t = cacheReq_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  payload_t inData,
    input  logic     hold,
    input  logic     flush,
    output logic     outValid,
    output payload_t outData
);

    // valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (flush) begin
            // drop whatever sits here
            outValid <= 1'b0;
        end else if (!hold) begin
            outValid <= inValid;
        end
    end

    // payload follows the input unless stalled
    always_ff @(posedge clk) begin
        if (!hold) begin
            outData <= inData;
        end
    end

endmodule

`default_nettype wire

// File: source/tagLookup.sv
// lookup is combinational on req; arrays are cleared by a BLOCKS-cycle sweep after reset
`default_nettype none
`include "cache_params.svh"

module tagLookup
    import cachePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  cacheReq_t              req,
    input  logic                   reqValid,
    input  logic                   install,
    input  logic [`TAG_BITS-1:0]   installTag,
    input  logic [`INDEX_BITS-1:0] installIndex,
    output lookupRes_t             res,
    output logic                   initDone
);

    // tag, valid and dirty per line
    tag_t tagMem   [`BLOCKS];
    logic validMem [`BLOCKS];
    logic dirtyMem [`BLOCKS];

    index_t sweepIdx;
    index_t reqIdx;
    logic   writeHit;

    assign reqIdx = req.addr.index;

    // hit when the line is valid and the tags match
    always_comb begin
        res.req         = req;
        res.hit         = validMem[reqIdx] && (tagMem[reqIdx] == addrTag(req.addr));
        // victim state only matters for a valid line
        res.victimDirty = validMem[reqIdx] && dirtyMem[reqIdx];
        res.victimTag   = tagMem[reqIdx];
    end

    // the line becomes dirty as the write passes lookup
    assign writeHit = reqValid && res.hit && !req.rNw;

    // sweep counter, one line per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            sweepIdx <= '0;
            initDone <= 1'b0;
        end else if (!initDone) begin
            sweepIdx <= sweepIdx + 1'b1;
            if (sweepIdx == index_t'(`BLOCKS - 1)) begin
                initDone <= 1'b1;
            end
        end
    end

    // array updates
    always_ff @(posedge clk) begin
        if (!initDone) begin
            validMem[sweepIdx] <= 1'b0;
            dirtyMem[sweepIdx] <= 1'b0;
        end else begin
            // a fresh line arrives clean
            if (install) begin
                tagMem[installIndex]   <= installTag;
                validMem[installIndex] <= 1'b1;
                dirtyMem[installIndex] <= 1'b0;
            end
            if (writeHit) begin
                dirtyMem[reqIdx] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/dataArray.sv
// reads are combinational; word writes act only on valid hits, installs replace the whole line
`default_nettype none
`include "cache_params.svh"

module dataArray
    import cachePkg::*;
    import memPkg::*;
(
    input  logic                   clk,
    input  lookupRes_t             res,
    input  logic                   resValid,
    input  logic                   install,
    input  logic [`INDEX_BITS-1:0] installIndex,
    input  line_t                  fillLine,
    input  logic [`INDEX_BITS-1:0] victimIndex,
    output line_t                  victimLine,
    output logic [31:0]            dataOut
);

    // 64 KB of line storage
    line_t lineMem [`BLOCKS];

    index_t                  wordIdx;
    logic [`OFFSET_BITS-1:0] wordSel;
    logic                    wordWrite;

    assign wordIdx = res.req.addr.index;
    assign wordSel = res.req.addr.offset;

    // only a hit may touch the line
    assign wordWrite = resValid && res.hit && !res.req.rNw;

    // word read for the stage-2 request
    assign dataOut = lineMem[wordIdx][wordSel];

    // whole victim line for writeback
    assign victimLine = lineMem[victimIndex];

    always_ff @(posedge clk) begin
        // new line from memory
        if (install) begin
            lineMem[installIndex] <= fillLine;
        end
        // store the word; a replayed write lands on the installed line
        if (wordWrite) begin
            lineMem[wordIdx][wordSel] <= res.req.dataIn;
        end
    end

endmodule

`default_nettype wire

// File: source/lineFill.sv
// one miss at a time; busy stays high during the reset sweep and the whole fill
`default_nettype none
`include "cache_params.svh"

module lineFill
    import cachePkg::*;
    import memPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  lookupRes_t res,
    input  logic       resValid,
    input  logic       initDone,
    input  line_t      victimLine,
    input  logic       rdValid,
    input  line_t      rdLine,
    output memReq_t    memReq,
    output logic       memStrobe,
    output logic       install,
    output line_t      fillLine,
    output logic       replay,
    output lookupRes_t replayRes,
    output logic       busy,
    output logic       evictValid
);

    typedef enum logic [2:0] {
        fillIdle,
        fillWriteback,
        fillFetch,
        fillInstall,
        fillReplay
    } fillState_t;

    fillState_t state;
    fillState_t nextState;

    // request that missed
    lookupRes_t pend;

    logic missNow;
    logic [`TAG_BITS+`INDEX_BITS-1:0] wbLine;
    logic [`TAG_BITS+`INDEX_BITS-1:0] fetchLine;

    assign missNow = resValid && !res.hit;

    always_comb begin
        nextState = state;
        case (state)
            fillIdle: begin
                // clean victims skip the writeback
                if (missNow) begin
                    nextState = res.victimDirty ? fillWriteback : fillFetch;
                end
            end
            fillWriteback: nextState = fillFetch;
            fillFetch:     nextState = fillInstall;
            fillInstall: begin
                if (rdValid) begin
                    nextState = fillReplay;
                end
            end
            fillReplay:    nextState = fillIdle;
            default:       nextState = fillIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fillIdle;
        end else begin
            state <= nextState;
        end
    end

    // latch the missing request as it leaves stage 2
    always_ff @(posedge clk) begin
        if (state == fillIdle && missNow) begin
            pend <= res;
        end
    end

    // full line addresses from tag and index
    assign wbLine    = {pend.victimTag, pend.req.addr.index};
    assign fetchLine = {addrTag(pend.req.addr), pend.req.addr.index};

    always_comb begin
        memReq.write    = (state == fillWriteback);
        memReq.lineAddr = memReq.write ? memAddr_t'(wbLine) : memAddr_t'(fetchLine);
        memReq.line     = victimLine;
    end

    // one strobe for the writeback, one for the fetch
    assign memStrobe  = (state == fillWriteback) || (state == fillFetch);
    assign evictValid = (state == fillWriteback);

    assign install  = (state == fillInstall) && rdValid;
    assign fillLine = rdLine;

    // replay the stored request, which now hits
    assign replay = (state == fillReplay);
    always_comb begin
        replayRes     = pend;
        replayRes.hit = 1'b1;
    end

    // raised in the same cycle as the miss pulse
    assign busy = !initDone || (state != fillIdle) || missNow;

endmodule

`default_nettype wire

// File: source/lineMemory.sv
// reset clears every line; reads return after MEM_LATENCY cycles, writes land at once
`default_nettype none
`include "cache_params.svh"

module lineMemory
    import memPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  memReq_t memReq,
    input  logic    memStrobe,
    output logic    rdValid,
    output line_t   rdLine
);

    line_t lineMem [`MEM_LINES];

    // read delay line, valid and address
    logic [`MEM_LATENCY-1:0] validPipe;
    memAddr_t                addrPipe [`MEM_LATENCY];

    // whole-line write, memory starts out all zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MEM_LINES; i++) begin
                lineMem[i] <= '0;
            end
        end else if (memStrobe && memReq.write) begin
            lineMem[memReq.lineAddr] <= memReq.line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[`MEM_LATENCY-2:0], memStrobe && !memReq.write};
        end
    end

    // addresses ride alongside the valid bits
    always_ff @(posedge clk) begin
        addrPipe[0] <= memReq.lineAddr;
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            addrPipe[i] <= addrPipe[i-1];
        end
    end

    assign rdValid = validPipe[`MEM_LATENCY-1];
    assign rdLine  = lineMem[addrPipe[`MEM_LATENCY-1]];

endmodule

`default_nettype wire

// File: source/cacheSubsystem.sv
// requester must keep en low while busy is high; hits complete two cycles after en
`default_nettype none

module cacheSubsystem
    import cachePkg::*;
    import memPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] addr,
    input  logic        en,
    input  logic        rNw,
    input  logic [31:0] dataIn,
    output logic [31:0] dataOut,
    output logic        hit,
    output logic        miss,
    output logic        busy,
    output logic        cacheEvictValid,
    output line_t       blkOut
);

    cacheReq_t  newReq, reqData, lookupReq;
    lookupRes_t lookupRes, lookIn, lookData, replayRes;
    logic       reqValid, lookupValid, lookValid;
    logic       initDone, install, replay, memStrobe, rdValid;
    line_t      victimLine, fillLine, rdLine;
    memReq_t    memReq;

    assign newReq.rNw    = rNw;
    assign newReq.addr   = cacheAddr_t'(addr);
    assign newReq.dataIn = dataIn;

    // stage 1 waits while a miss is serviced
    stageReg #(.payload_t(cacheReq_t)) reqStage_i (
        .clk(clk), .rst(rst), .inValid(en), .inData(newReq), .hold(busy),
        .flush(1'b0), .outValid(reqValid), .outData(reqData)
    );

    // the replay goes through lookup too, so a replayed write marks the line dirty
    assign lookupReq   = replay ? replayRes.req : reqData;
    assign lookupValid = replay || (reqValid && !busy);

    tagLookup tagLookup_i (
        .clk(clk), .rst(rst), .req(lookupReq), .reqValid(lookupValid), .install(install),
        .installTag(addrTag(replayRes.req.addr)), .installIndex(replayRes.req.addr.index),
        .res(lookupRes), .initDone(initDone)
    );

    // the missing request is dropped from stage 2 once the fill starts
    assign lookIn = replay ? replayRes : lookupRes;
    stageReg #(.payload_t(lookupRes_t)) lookStage_i (
        .clk(clk), .rst(rst), .inValid(replay || reqValid), .inData(lookIn), .hold(1'b0),
        .flush(busy && !replay), .outValid(lookValid), .outData(lookData)
    );

    dataArray dataArray_i (
        .clk(clk), .res(lookData), .resValid(lookValid), .install(install),
        .installIndex(replayRes.req.addr.index), .fillLine(fillLine),
        .victimIndex(replayRes.req.addr.index), .victimLine(victimLine), .dataOut(dataOut)
    );

    lineFill lineFill_i (
        .clk(clk), .rst(rst), .res(lookData), .resValid(lookValid), .initDone(initDone),
        .victimLine(victimLine), .rdValid(rdValid), .rdLine(rdLine), .memReq(memReq),
        .memStrobe(memStrobe), .install(install), .fillLine(fillLine), .replay(replay),
        .replayRes(replayRes), .busy(busy), .evictValid(cacheEvictValid)
    );

    lineMemory lineMemory_i (
        .clk(clk), .rst(rst), .memReq(memReq), .memStrobe(memStrobe),
        .rdValid(rdValid), .rdLine(rdLine)
    );

    // stage-2 outcome
    assign hit  = lookValid && lookData.hit;
    assign miss = lookValid && !lookData.hit;
    // victim line as sent to memory
    assign blkOut = memReq.line;

endmodule

`default_nettype wire

// File: verif/cacheTb.sv
// keeps byte addresses below 256 KB; requests wait for busy low except bursts to a resident line
`default_nettype none
`include "cache_params.svh"

module cacheTb
    import memPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // address field positions, byte lanes at the bottom
    localparam int IDX_LO = `OFFSET_BITS + 2;
    localparam int TAG_LO = IDX_LO + `INDEX_BITS;
    // cycles allowed for one miss, writeback included
    localparam int MISS_LIMIT = 64;

    typedef struct packed {
        logic        rNw;
        logic [31:0] addr;
        logic [31:0] data;
    } access_t;

    logic        clk, rst, en, rNw, hit, miss, busy, cacheEvictValid;
    logic [31:0] addr, dataIn, dataOut;
    line_t       blkOut;

    // reference memory by word address, absent words read 0
    logic [31:0] memModel [logic [29:0]];
    // shadow of the direct-mapped tag store
    logic [31:0] shadowTag   [`BLOCKS];
    logic        shadowValid [`BLOCKS];
    logic        shadowDirty [`BLOCKS];
    integer      seed;

    cacheSubsystem dut_i (
        .clk(clk), .rst(rst), .addr(addr), .en(en), .rNw(rNw), .dataIn(dataIn),
        .dataOut(dataOut), .hit(hit), .miss(miss), .busy(busy),
        .cacheEvictValid(cacheEvictValid), .blkOut(blkOut)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expectEq(input string name, input logic [511:0] got, input logic [511:0] exp);
        assert (got === exp) else begin
            failRun($sformatf("MISMATCH at time %0t: %s got %0h expected %0h",
                              $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] modelRead(input logic [31:0] a);
        return memModel.exists(a[31:2]) ? memModel[a[31:2]] : 32'h0;
    endfunction

    // whole line as the model sees it
    function automatic line_t modelLine(input logic [31:0] base);
        line_t l;
        for (int w = 0; w < `WORDS; w++) begin
            l[w] = modelRead(base + 32'(w * 4));
        end
        return l;
    endfunction

    // a few hot indices and four tags, so lines keep conflicting
    function automatic logic [31:0] randAddr();
        logic [31:0] tag;
        logic [31:0] idx;
        logic [31:0] off;
        tag = $random(seed) & 3;
        idx = 32'h100 + ($random(seed) & 7);
        off = $random(seed) & 15;
        return (tag << TAG_LO) | (idx << IDX_LO) | (off << 2);
    endfunction

    // wait at falling edges until the cache takes requests again
    task automatic waitIdle(input int limit);
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            if (n > limit) failRun("timeout: busy did not fall");
        end
    endtask

    task automatic drive(input access_t r);
        en     = 1'b1;
        rNw    = r.rNw;
        addr   = r.addr;
        dataIn = r.data;
    endtask

    // one request, followed through any fill to its final hit
    task automatic access(input access_t r);
        int          idx;
        int          n;
        int          evicts;
        logic        expHit;
        logic        expEvict;
        logic [31:0] tag;
        logic [31:0] expData;
        line_t       victim;
        waitIdle(MISS_LIMIT);
        idx      = int'(r.addr[TAG_LO-1:IDX_LO]);
        tag      = r.addr >> TAG_LO;
        expHit   = shadowValid[idx] && (shadowTag[idx] == tag);
        expEvict = !expHit && shadowValid[idx] && shadowDirty[idx];
        victim   = modelLine((shadowTag[idx] << TAG_LO) | (idx << IDX_LO));
        expData  = modelRead(r.addr);
        drive(r);
        @(negedge clk);
        en = 1'b0;
        @(negedge clk);
        // outcome two cycles after en
        expectEq("hit", hit, expHit);
        expectEq("miss", miss, !expHit);
        n = 0;
        evicts = 0;
        while (!hit) begin
            @(negedge clk);
            n++;
            if (n > MISS_LIMIT) failRun("timeout: missed request never completed");
            expectEq("miss", miss, 1'b0);
            if (cacheEvictValid) begin
                evicts++;
                expectEq("blkOut", blkOut, victim);
            end
        end
        expectEq("cacheEvictValid pulses", evicts, expEvict);
        if (r.rNw) expectEq("dataOut", dataOut, expData);
        if (!r.rNw) memModel[r.addr[31:2]] = r.data;
        // a fill brings the line in clean, a write dirties it
        shadowDirty[idx] = (expHit && shadowDirty[idx]) || !r.rNw;
        shadowValid[idx] = 1'b1;
        shadowTag[idx]   = tag;
    endtask

    // back-to-back requests into one resident line
    task automatic burst(input logic [31:0] base, input int count);
        access_t     reqs    [16];
        logic [31:0] expData [16];
        waitIdle(MISS_LIMIT);
        for (int i = 0; i < count + 2; i++) begin
            if (i >= 2) begin
                expectEq("hit", hit, 1'b1);
                expectEq("busy", busy, 1'b0);
                if (reqs[i-2].rNw) expectEq("dataOut", dataOut, expData[i-2]);
            end
            if (i < count) begin
                reqs[i].rNw  = 1'($random(seed));
                reqs[i].addr = base | 32'(($random(seed) & 15) << 2);
                reqs[i].data = $random(seed);
                expData[i]   = modelRead(reqs[i].addr);
                if (!reqs[i].rNw) begin
                    memModel[reqs[i].addr[31:2]] = reqs[i].data;
                    shadowDirty[reqs[i].addr[TAG_LO-1:IDX_LO]] = 1'b1;
                end
                drive(reqs[i]);
            end else begin
                en = 1'b0;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        access_t     r;
        logic [31:0] lineA;
        int          n;
        seed   = 32'h4f4a_edaf;
        rst    = 1'b1;
        en     = 1'b0;
        rNw    = 1'b1;
        addr   = '0;
        dataIn = '0;
        for (int i = 0; i < `BLOCKS; i++) begin
            shadowTag[i]   = '0;
            shadowValid[i] = 1'b0;
            shadowDirty[i] = 1'b0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        // init sweep, outputs stay quiet until busy falls
        n = 0;
        while (busy) begin
            expectEq("hit", hit, 1'b0);
            expectEq("miss", miss, 1'b0);
            expectEq("cacheEvictValid", cacheEvictValid, 1'b0);
            @(negedge clk);
            n++;
            if (n > `BLOCKS + 8) failRun("timeout: busy did not fall after reset");
        end
        lineA = 32'h0000_2040;
        // cold miss, then a direct hit on the same word
        access(access_t'{1'b1, lineA, 32'h0});
        access(access_t'{1'b1, lineA, 32'h0});
        access(access_t'{1'b0, lineA + 32'd12, 32'ha5a5_0003});
        // same index, other tag, evicts the dirty line
        access(access_t'{1'b1, lineA + 32'h1_0000, 32'h0});
        // write miss on a clean victim, line comes back from memory
        access(access_t'{1'b0, lineA + 32'd28, 32'h5a5a_0007});
        for (int w = 0; w < `WORDS; w++) begin
            access(access_t'{1'b1, lineA + 32'(w * 4), 32'h0});
        end
        burst(lineA, 12);
        for (int i = 0; i < 300; i++) begin
            r.rNw  = 1'($random(seed));
            r.addr = randAddr();
            r.data = $random(seed);
            access(r);
            if (i % 10 == 9) burst(r.addr & ~32'h3f, 6);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/cachePkg.sv
source/memPkg.sv
source/stageReg.sv
source/tagLookup.sv
source/dataArray.sv
source/lineFill.sv
source/lineMemory.sv
source/cacheSubsystem.sv
verif/cacheTb.sv
